//--- spi_reg_pkg.sv
// ------------------------------
// spi register access constants
// frame layout, command codes, address map, id words
// ------------------------------

`default_nettype none

package spi_reg_pkg;

	// ------------------------------
	// field widths and commands
	// ------------------------------
	localparam int CMD_W  = 8;	// command field
	localparam int ADDR_W = 16;	// address field
	localparam int DATA_W = 16;	// data field

	localparam logic [CMD_W-1:0] CMD_WR = 8'h80;	// write frame
	localparam logic [CMD_W-1:0] CMD_RD = 8'h81;	// read frame

	// shifter sized for the widest field
	localparam int SHIFT_W = (CMD_W >= ADDR_W && CMD_W >= DATA_W) ? CMD_W :
		((ADDR_W >= DATA_W) ? ADDR_W : DATA_W);

	// ------------------------------
	// rising edge counts in a frame
	// ------------------------------
	localparam int CNT_W = 7;	// counter width, holds 0..40

	localparam logic [CNT_W-1:0] CNT_ADDR_LAST  = 7'd23;	// last address bit
	localparam logic [CNT_W-1:0] CNT_RD_LOAD    = 7'd24;	// read word load, falling edge
	localparam logic [CNT_W-1:0] CNT_FRAME_LAST = 7'd39;	// last data bit
	localparam logic [CNT_W-1:0] CNT_SAT        = 7'd40;	// counter stops here
	localparam logic [CNT_W-1:0] CNT_WR_CLR     = 7'd4;	// old write strobe drops

	// ------------------------------
	// address map
	// ------------------------------
	localparam logic [ADDR_W-1:0] CTRL_BASE = 16'h0000;
	localparam logic [ADDR_W-1:0] CTRL_REGS = 16'd16;	// control bank depth
	localparam logic [ADDR_W-1:0] ID_BASE   = 16'h0100;
	localparam logic [ADDR_W-1:0] ID_REGS   = 16'd4;	// id block depth

	// identification words, entry 0 at ID_BASE
	localparam logic [DATA_W-1:0] ID_WORDS [ID_REGS] = '{
		16'h5A31,	// device id
		16'h0102,	// firmware revision
		16'h0040,	// feature bits
		16'hC0DE	// signature
	};

	localparam int CTRL_MODE_IDX = 0;	// exported as mode
	localparam int CTRL_GAIN_IDX = 1;	// exported as gain

endpackage

`default_nettype wire

//--- id_reg_rom.sv
// ------------------------------
// id_reg_rom
// read only identification words
// ------------------------------

`default_nettype none

module id_reg_rom import spi_reg_pkg::*; (
	input  wire  [ADDR_W-1:0] i_addr,
	output logic              o_sel,	// address inside the id window
	output logic [DATA_W-1:0] o_rd_data
);

	logic [ADDR_W-1:0]          id_off;	// offset from ID_BASE
	logic                       id_hit;
	logic [$clog2(ID_REGS)-1:0] id_idx;

	assign id_off = i_addr - ID_BASE;	// wraps below base, so no hit
	assign id_hit = (id_off < ID_REGS);
	assign id_idx = id_off[$clog2(ID_REGS)-1:0];

	// constant lookup
	always_comb begin
		if (id_hit) begin
			o_rd_data = ID_WORDS[id_idx];
		end else begin
			o_rd_data = '0;
		end
	end

	assign o_sel = id_hit;

endmodule

`default_nettype wire

//--- ctrl_reg_bank.sv
// ------------------------------
// ctrl_reg_bank
// sixteen r/w control registers on the spi bus
// ------------------------------

`default_nettype none

module ctrl_reg_bank import spi_reg_pkg::*; (
	input  wire               i_spi_clk,
	input  wire               i_wr_en,	// strobe level from the slave
	input  wire  [ADDR_W-1:0] i_addr,
	input  wire  [DATA_W-1:0] i_wr_data,
	output logic              o_sel,	// address inside the bank
	output logic [DATA_W-1:0] o_rd_data,
	output logic [DATA_W-1:0] o_ctrl_mode,
	output logic [DATA_W-1:0] o_ctrl_gain
);

	// ------------------------------
	// address decode
	// ------------------------------
	logic [ADDR_W-1:0]            ctrl_off;	// offset from bank base
	logic                         ctrl_hit;
	logic [$clog2(CTRL_REGS)-1:0] ctrl_idx;	// word select

	// bank powers up cleared, cs high never touches it
	logic [DATA_W-1:0] ctrl_regs [CTRL_REGS] = '{default: '0};

	assign ctrl_off = i_addr - CTRL_BASE;
	assign ctrl_hit = (ctrl_off < CTRL_REGS);
	assign ctrl_idx = ctrl_off[$clog2(CTRL_REGS)-1:0];

	// ------------------------------
	// write commit
	// ------------------------------
	// the strobe is high across the cs gap, so the store lands on
	// the first rising edge of the following frame
	always_ff @(posedge i_spi_clk) begin
		if (i_wr_en && ctrl_hit) begin
			ctrl_regs[ctrl_idx] <= i_wr_data;
		end
	end

	// ------------------------------
	// read return and exports
	// ------------------------------
	always_comb begin
		if (ctrl_hit) begin
			o_rd_data = ctrl_regs[ctrl_idx];
		end else begin
			o_rd_data = '0;
		end
	end

	assign o_sel       = ctrl_hit;
	assign o_ctrl_mode = ctrl_regs[CTRL_MODE_IDX];	// reg 0
	assign o_ctrl_gain = ctrl_regs[CTRL_GAIN_IDX];	// reg 1

endmodule

`default_nettype wire

//--- spi_slave.sv
// ------------------------------
// spi_slave
// parses cmd/addr/data frames, drives register bus
// and shifts the read word out on miso
// ------------------------------

`default_nettype none

module spi_slave import spi_reg_pkg::*; (
	input  wire               i_spi_clk,	// host sck, sampled on rise
	input  wire               i_spi_cs_n,	// high resets frame logic
	input  wire               i_spi_mosi,
	output logic              o_spi_miso,
	output logic              o_spi_miso_en,	// 1 while read word is on miso
	output logic              o_wr_en,	// write strobe level
	output logic              o_rd_en,	// read frame past address
	output logic [ADDR_W-1:0] o_addr,
	output logic [DATA_W-1:0] o_wr_data,
	input  wire               i_id_sel,
	input  wire  [DATA_W-1:0] i_id_rd_data,
	input  wire               i_ctrl_sel,
	input  wire  [DATA_W-1:0] i_ctrl_rd_data
);

	logic [CNT_W-1:0]   sck_cnt;	// rising edges seen this frame
	logic [SHIFT_W-1:0] shifter;	// mosi history
	logic               cmd_wr;
	logic               cmd_rd;
	logic [ADDR_W-1:0]  addr_q;
	logic [DATA_W-1:0]  wr_data_q;
	logic               wr_en_q = 1'b0;	// survives cs high between frames
	logic               rd_en_q;
	logic [DATA_W-1:0]  rd_src;	// prioritized read word
	logic [DATA_W-1:0]  rd_word;	// falling edge shifter
	logic               rd_shift_en;

	// ------------------------------
	// mosi side, rising edges
	// ------------------------------

	// saturating edge count
	always_ff @(posedge i_spi_clk or posedge i_spi_cs_n) begin
		if (i_spi_cs_n) begin
			sck_cnt <= '0;
		end else if (sck_cnt != CNT_SAT) begin
			sck_cnt <= sck_cnt + 1'b1;
		end
	end

	always_ff @(posedge i_spi_clk or posedge i_spi_cs_n) begin
		if (i_spi_cs_n) begin
			shifter <= '0;
		end else begin
			shifter <= {shifter[SHIFT_W-2:0], i_spi_mosi};	// msb first
		end
	end

	// command flags, decoded once all 8 bits are in
	always_ff @(posedge i_spi_clk or posedge i_spi_cs_n) begin
		if (i_spi_cs_n) begin
			cmd_wr <= 1'b0;
			cmd_rd <= 1'b0;
		end else if (sck_cnt == CNT_W'(CMD_W)) begin
			case (shifter[CMD_W-1:0])
				CMD_WR: begin
					cmd_wr <= 1'b1;
					cmd_rd <= 1'b0;
				end
				CMD_RD: begin
					cmd_wr <= 1'b0;
					cmd_rd <= 1'b1;
				end
				default: begin	// unknown cmd, frame ignored
					cmd_wr <= 1'b0;
					cmd_rd <= 1'b0;
				end
			endcase
		end
	end

	// address grabbed together with its last bit
	always_ff @(posedge i_spi_clk) begin
		if (sck_cnt == CNT_ADDR_LAST) begin
			addr_q <= {shifter[ADDR_W-2:0], i_spi_mosi};
		end
	end

	always_ff @(posedge i_spi_clk) begin
		if (sck_cnt == CNT_FRAME_LAST) begin
			wr_data_q <= {shifter[DATA_W-2:0], i_spi_mosi};
		end
	end

	// write strobe
	// set at end of a write frame, held over the cs gap, dropped a few
	// edges into the next frame so the bank commits on its first edge
	always_ff @(posedge i_spi_clk) begin
		if (sck_cnt == CNT_WR_CLR) begin
			wr_en_q <= 1'b0;
		end else if (sck_cnt == CNT_FRAME_LAST) begin
			wr_en_q <= cmd_wr;
		end
	end

	always_ff @(posedge i_spi_clk or posedge i_spi_cs_n) begin
		if (i_spi_cs_n) begin
			rd_en_q <= 1'b0;
		end else if (sck_cnt == CNT_ADDR_LAST) begin
			rd_en_q <= cmd_rd;
		end
	end

	// ------------------------------
	// miso side, falling edges
	// ------------------------------

	// fixed priority, id block before control bank
	always_comb begin
		if (i_id_sel) begin
			rd_src = i_id_rd_data;
		end else if (i_ctrl_sel) begin
			rd_src = i_ctrl_rd_data;
		end else begin
			rd_src = '0;	// unmapped
		end
	end

	// load after edge 24, then rotate one bit per falling edge
	always_ff @(negedge i_spi_clk) begin
		if (sck_cnt == CNT_RD_LOAD) begin
			rd_word <= rd_src;
		end else if (rd_shift_en) begin
			rd_word <= {rd_word[DATA_W-2:0], rd_word[DATA_W-1]};
		end
	end

	always_ff @(negedge i_spi_clk or posedge i_spi_cs_n) begin
		if (i_spi_cs_n) begin
			rd_shift_en <= 1'b0;
		end else if (sck_cnt == CNT_RD_LOAD) begin
			rd_shift_en <= 1'b1;
		end
	end

	assign o_spi_miso    = rd_word[DATA_W-1];
	assign o_spi_miso_en = rd_shift_en & cmd_rd;	// only read frames drive
	assign o_wr_en       = wr_en_q;
	assign o_rd_en       = rd_en_q;
	assign o_addr        = addr_q;
	assign o_wr_data     = wr_data_q;

endmodule

`default_nettype wire

//--- spi_reg_top.sv
// ------------------------------
// spi_reg_top
// spi slave with control bank and id block
// ------------------------------

`default_nettype none

module spi_reg_top import spi_reg_pkg::*; (
	input  wire               i_spi_clk,
	input  wire               i_spi_cs_n,
	input  wire               i_spi_mosi,
	output logic              o_spi_miso,	// pad tristate lives a level up
	output logic              o_spi_miso_en,
	output logic [DATA_W-1:0] o_ctrl_mode,
	output logic [DATA_W-1:0] o_ctrl_gain
);

	// register bus
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wr_data;
	logic              wr_en;
	logic              rd_en;	// no external read port here
	logic              id_sel;
	logic [DATA_W-1:0] id_rd_data;
	logic              ctrl_sel;
	logic [DATA_W-1:0] ctrl_rd_data;

	spi_slave u_spi_slave (
		.i_spi_clk      (i_spi_clk),
		.i_spi_cs_n     (i_spi_cs_n),
		.i_spi_mosi     (i_spi_mosi),
		.o_spi_miso     (o_spi_miso),
		.o_spi_miso_en  (o_spi_miso_en),
		.o_wr_en        (wr_en),
		.o_rd_en        (rd_en),
		.o_addr         (addr),
		.o_wr_data      (wr_data),
		.i_id_sel       (id_sel),
		.i_id_rd_data   (id_rd_data),
		.i_ctrl_sel     (ctrl_sel),
		.i_ctrl_rd_data (ctrl_rd_data)
	);

	ctrl_reg_bank u_ctrl_reg_bank (
		.i_spi_clk   (i_spi_clk),
		.i_wr_en     (wr_en),
		.i_addr      (addr),
		.i_wr_data   (wr_data),
		.o_sel       (ctrl_sel),
		.o_rd_data   (ctrl_rd_data),
		.o_ctrl_mode (o_ctrl_mode),
		.o_ctrl_gain (o_ctrl_gain)
	);

	id_reg_rom u_id_reg_rom (
		.i_addr    (addr),
		.o_sel     (id_sel),
		.o_rd_data (id_rd_data)
	);

endmodule

`default_nettype wire

//--- tb_spi_reg_top.sv
// ------------------------------
// tb_spi_reg_top
// directed frame tests for the spi register slave,
// host side bit-banged on a free running sck
// ------------------------------

`default_nettype none

module tb_spi_reg_top;

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 4;
	localparam int GAP_CYCLES   = 4;	// cs high between frames
	localparam int FRAME_EDGES  = 40;	// 8 cmd + 16 addr + 16 data
	localparam int FRAME_CYCLES = 48;	// budget per frame with gap
	localparam int N_FRAMES     = 22;	// all frames of all tests
	localparam int TIMEOUT      =
		(N_FRAMES * FRAME_CYCLES + RESET_CYCLES + 64) * CLK_PERIOD;

	localparam logic [7:0] WR_CMD  = 8'h80;
	localparam logic [7:0] RD_CMD  = 8'h81;
	localparam logic [7:0] BAD_CMD = 8'h55;	// neither read nor write

	// id block contents as listed in the address map
	localparam logic [15:0] ID_ADDR    = 16'h0100;
	localparam logic [15:0] ID_EXP [4] = '{16'h5A31, 16'h0102, 16'h0040, 16'hC0DE};

	localparam logic [15:0] WR_ADDRS [5] = '{16'h0000, 16'h0001, 16'h0005,
		16'h000A, 16'h000F};

	logic        spi_clk;
	logic        spi_cs_n;
	logic        spi_mosi;
	wire         spi_miso;
	wire         spi_miso_en;
	wire  [15:0] ctrl_mode;
	wire  [15:0] ctrl_gain;

	integer      seed;
	int          errors;
	int          checks;
	logic [15:0] ctrl_model [16];	// expected bank contents

	spi_reg_top DUT (
		.i_spi_clk     (spi_clk),
		.i_spi_cs_n    (spi_cs_n),
		.i_spi_mosi    (spi_mosi),
		.o_spi_miso    (spi_miso),
		.o_spi_miso_en (spi_miso_en),
		.o_ctrl_mode   (ctrl_mode),
		.o_ctrl_gain   (ctrl_gain)
	);

	// ------------------------------
	// clock and watchdog
	// ------------------------------
	initial begin
		spi_clk = 1'b0;
	end

	always #(CLK_PERIOD / 2) spi_clk = ~spi_clk;

	initial begin
		#(TIMEOUT);
		$display("timeout: frames still running after %0d time units", TIMEOUT);
		$display("Errors found");
		$finish;
	end

	// ------------------------------
	// helpers
	// ------------------------------
	task automatic check(input string name, input logic [15:0] got,
		input logic [15:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("FAIL at %0t: %s got 0x%04h expected 0x%04h",
				$time, name, got, expected);
		end
	endtask

	// one full frame, mosi changes one edge ahead of the dut sample
	task automatic run_frame(input logic [7:0] cmd, input logic [15:0] addr,
		input logic [15:0] data, output logic [15:0] miso_word,
		output int en_early, output int en_late);
		logic [39:0] bits;
		bits      = {cmd, addr, data};
		miso_word = 16'h0000;
		en_early  = 0;
		en_late   = 0;
		@(posedge spi_clk);
		spi_cs_n <= 1'b0;
		spi_mosi <= bits[39];	// msb first
		for (int k = 1; k <= FRAME_EDGES; k++) begin
			@(posedge spi_clk);
			// pre-edge values, miso only moves on falling edges
			if (k <= 24) begin
				if (spi_miso_en) begin
					en_early++;
				end
			end else begin
				miso_word = {miso_word[14:0], spi_miso};
				if (spi_miso_en) begin
					en_late++;
				end
			end
			if (k < FRAME_EDGES) begin
				spi_mosi <= bits[FRAME_EDGES-1-k];
			end else begin
				spi_cs_n <= 1'b1;	// frame done after edge 40
				spi_mosi <= 1'b0;
			end
		end
		repeat (GAP_CYCLES) @(posedge spi_clk);
	endtask

	task automatic spi_write(input logic [15:0] addr, input logic [15:0] data);
		logic [15:0] word;
		int          en_early;
		int          en_late;
		run_frame(WR_CMD, addr, data, word, en_early, en_late);
		check($sformatf("miso_en in write @%04h", addr), 16'(en_early + en_late), 16'd0);
	endtask

	task automatic spi_read(input logic [15:0] addr, input logic [15:0] expected);
		logic [15:0] word;
		int          en_early;
		int          en_late;
		run_frame(RD_CMD, addr, 16'h0000, word, en_early, en_late);
		check($sformatf("read data @%04h", addr), word, expected);
		check($sformatf("miso_en edges 1-24 @%04h", addr), 16'(en_early), 16'd0);
		check($sformatf("miso_en edges 25-40 @%04h", addr), 16'(en_late), 16'd16);
	endtask

	// ------------------------------
	// directed tests
	// ------------------------------
	task automatic reset_state();
		check("miso_en after reset", {15'd0, spi_miso_en}, 16'd0);
		check("ctrl_mode power-up", ctrl_mode, 16'h0000);	// bank starts cleared
		check("ctrl_gain power-up", ctrl_gain, 16'h0000);
	endtask

	task automatic write_read_back();
		logic [15:0] data;
		for (int i = 0; i < 5; i++) begin
			data = 16'($random(seed));
			spi_write(WR_ADDRS[i], data);
			ctrl_model[WR_ADDRS[i][3:0]] = data;
		end
		for (int i = 0; i < 5; i++) begin
			spi_read(WR_ADDRS[i], ctrl_model[WR_ADDRS[i][3:0]]);
		end
		check("ctrl_mode", ctrl_mode, ctrl_model[0]);
		check("ctrl_gain", ctrl_gain, ctrl_model[1]);
	endtask

	// exports follow a fresh write once the next frame has started
	task automatic export_update();
		logic [15:0] data;
		data = 16'($random(seed));
		spi_write(16'h0000, data);
		ctrl_model[0] = data;
		spi_read(16'h0001, ctrl_model[1]);
		check("ctrl_mode after update", ctrl_mode, ctrl_model[0]);
		data = 16'($random(seed));
		spi_write(16'h0001, data);
		ctrl_model[1] = data;
		spi_read(16'h0000, ctrl_model[0]);
		check("ctrl_gain after update", ctrl_gain, ctrl_model[1]);
	endtask

	task automatic id_words_read();
		for (int i = 0; i < 4; i++) begin
			spi_read(ID_ADDR + 16'(i), ID_EXP[i]);
		end
	endtask

	task automatic unmapped_read();
		spi_read(16'h0200, 16'h0000);	// hole above id block
		spi_read(16'h0010, 16'h0000);	// just past the control bank
	endtask

	task automatic bad_command();
		logic [15:0] word;
		int          en_early;
		int          en_late;
		// inverted data so a stray write would show
		run_frame(BAD_CMD, 16'h0005, ~ctrl_model[5], word, en_early, en_late);
		check("miso_en in bad cmd frame", 16'(en_early + en_late), 16'd0);
		spi_read(16'h0005, ctrl_model[5]);
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		spi_cs_n = 1'b1;	// frame logic held in reset
		spi_mosi = 1'b0;
		seed     = 93058;
		errors   = 0;
		checks   = 0;
		for (int i = 0; i < 16; i++) begin
			ctrl_model[i] = 16'h0000;
		end
		repeat (RESET_CYCLES) @(posedge spi_clk);

		reset_state();
		write_read_back();
		export_update();
		id_words_read();
		unmapped_read();
		bad_command();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
spi_reg_pkg.sv
id_reg_rom.sv
ctrl_reg_bank.sv
spi_slave.sv
spi_reg_top.sv
tb_spi_reg_top.sv

//--- Makefile
# Verilator flow for the SPI register slave
# lint checks the RTL top, sim runs the testbench and searches the log

TOP = tb_spi_reg_top
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f project.f --top-module spi_reg_top

sim:
	verilator --binary --timing -f project.f --top-module $(TOP) --Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "No errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
